/* icache_params.svh */
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Fetch address split
`define ICACHE_ADDR_W   32
`define ICACHE_OFFSET_W 4
`define ICACHE_INDEX_W  4
`define ICACHE_TAG_W    (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// Number of sets follows from the index width
`define ICACHE_SETS     (1 << `ICACHE_INDEX_W)

// Associativity, 2 or 4
`define ICACHE_WAYS     2

// Way number needs at least one bit even for a single way
`define ICACHE_WAY_W    ((`ICACHE_WAYS > 2) ? $clog2(`ICACHE_WAYS) : 1)

`endif

/* icache_pkg.sv */
`include "icache_params.svh"

package icache_pkg;

    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] set_idx_t;
    typedef logic [`ICACHE_WAY_W-1:0]   way_idx_t;
    typedef logic [`ICACHE_WAYS-1:0]    way_vec_t;

    typedef enum logic [1:0] {
        MAINT_FILL  = 2'd0,
        MAINT_INVAL = 2'd1,
        MAINT_FLUSH = 2'd2
    } maint_op_t;

    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
    } lookup_req_t;

    typedef struct packed {
        maint_op_t op;
        way_idx_t  way;
        set_idx_t  index;
        tag_t      tag;
    } maint_cmd_t;

    // Broadcast to every way
    typedef struct packed {
        set_idx_t rd_index;
        set_idx_t cmp_index;
        tag_t     cmp_tag;
        set_idx_t wr_index;
        tag_t     wr_tag;
        way_vec_t we;
        way_vec_t inval;
        logic     flush;
    } way_ctrl_t;

    typedef struct packed {
        logic match;
        logic valid;
    } way_probe_t;

    typedef struct packed {
        logic     hit;
        way_idx_t hit_way;
        way_idx_t victim;
        set_idx_t index;
    } lookup_resp_t;

endpackage

/* tag_ram.sv */
`include "icache_params.svh"

module tag_ram (
    input  logic                       clk,
    input  logic [`ICACHE_INDEX_W-1:0] waddr,
    input  logic [`ICACHE_INDEX_W-1:0] raddr,
    input  logic                       we,
    input  logic [`ICACHE_TAG_W-1:0]   din,
    output logic [`ICACHE_TAG_W-1:0]   dout
);

    logic [`ICACHE_TAG_W-1:0] mem [`ICACHE_SETS];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

    // Registered read, returns the old word on a same-address write
    always_ff @(posedge clk) begin
        dout <= mem[raddr];
    end

endmodule

/* icache_tag_way.sv */
`include "icache_params.svh"

module icache_tag_way
    import icache_pkg::*;
#(
    parameter int WAY_ID = 0
) (
    input  logic       clk,
    input  logic       reset,
    input  way_ctrl_t  ctrl,
    output way_probe_t probe
);

    logic                    way_we;
    logic                    way_inval;
    logic                    ram_we;
    tag_t                    ram_din;
    tag_t                    ram_dout;
    logic                    same_set;
    logic [`ICACHE_SETS-1:0] valid_bits;
    logic                    rd_valid;
    logic                    fwd_q;
    tag_t                    fwd_tag;
    tag_t                    rd_tag;

    // Pick this way's bits out of the broadcast vectors
    assign way_we    = ctrl.we[WAY_ID];
    assign way_inval = ctrl.inval[WAY_ID];

    // Invalidate also zeroes the stored tag
    assign ram_we   = way_we || way_inval;
    assign ram_din  = way_inval ? '0 : ctrl.wr_tag;
    assign same_set = (ctrl.wr_index == ctrl.rd_index);

    tag_ram u_tag_ram (
        .clk   (clk),
        .waddr (ctrl.wr_index),
        .raddr (ctrl.rd_index),
        .we    (ram_we),
        .din   (ram_din),
        .dout  (ram_dout)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Valid bits
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || ctrl.flush) begin
            valid_bits <= '0;
        end else if (way_inval) begin
            valid_bits[ctrl.wr_index] <= 1'b0;
        end else if (way_we) begin
            valid_bits[ctrl.wr_index] <= 1'b1;
        end
    end

    // Valid for the set being read, with same-cycle updates forwarded
    always_ff @(posedge clk) begin
        if (reset || ctrl.flush) begin
            rd_valid <= 1'b0;
        end else if (same_set && way_inval) begin
            rd_valid <= 1'b0;
        end else if (same_set && way_we) begin
            rd_valid <= 1'b1;
        end else begin
            rd_valid <= valid_bits[ctrl.rd_index];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tag forwarding and compare
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            fwd_q <= 1'b0;
        end else begin
            fwd_q <= ram_we && same_set;
        end
    end

    always_ff @(posedge clk) begin
        fwd_tag <= ram_din;
    end

    assign rd_tag      = fwd_q ? fwd_tag : ram_dout;
    assign probe.match = (rd_tag == ctrl.cmp_tag);
    assign probe.valid = rd_valid;

endmodule

/* icache_lookup_ctrl.sv */
`include "icache_params.svh"

module icache_lookup_ctrl
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        req_valid,
    output logic        req_ready,
    input  lookup_req_t req,

    input  logic        maint_valid,
    input  maint_cmd_t  maint,

    input  logic        stall,
    output way_ctrl_t   ctrl,
    output logic        stage_valid
);

    tag_t     req_tag;
    set_idx_t req_index;
    tag_t     cmp_tag_q;
    set_idx_t index_q;
    logic     stage_valid_q;
    logic     req_fire;

    // Address split: tag | index | offset
    assign req_tag   = req.addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign req_index = req.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

    // Only a full response register blocks new lookups
    assign req_ready = !stall;
    assign req_fire  = req_valid && req_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Stage one
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid_q <= 1'b0;
        end else if (!stall) begin
            stage_valid_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            cmp_tag_q <= req_tag;
            index_q   <= req_index;
        end
    end

    assign stage_valid = stage_valid_q;

    ////////////////////////////////////////////////////////////////////////////
    // Way control
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Re-read the held set while stalled so the RAM output stays put
        ctrl.rd_index  = stall ? index_q : req_index;
        ctrl.cmp_index = index_q;
        ctrl.cmp_tag   = cmp_tag_q;
        ctrl.wr_index  = maint.index;
        ctrl.wr_tag    = maint.tag;
        ctrl.we        = '0;
        ctrl.inval     = '0;
        ctrl.flush     = 1'b0;

        if (maint_valid) begin
            case (maint.op)
                MAINT_FILL:  ctrl.we[maint.way]    = 1'b1;
                MAINT_INVAL: ctrl.inval[maint.way] = 1'b1;
                MAINT_FLUSH: ctrl.flush            = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

/* icache_hit_resolve.sv */
`include "icache_params.svh"

module icache_hit_resolve
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  logic         stage_valid,
    input  way_probe_t   probes [`ICACHE_WAYS],
    input  set_idx_t     index,

    output logic         resp_valid,
    input  logic         resp_ready,
    output lookup_resp_t resp,

    output logic         stall
);

    way_idx_t mru [`ICACHE_SETS];
    way_idx_t mru_cur;
    way_idx_t mru_next;
    logic     hit;
    way_idx_t hit_way;
    logic     has_invalid;
    way_idx_t invalid_way;
    way_idx_t victim;
    logic     load;

    assign stall = resp_valid && !resp_ready;
    assign load  = stage_valid && !stall;

    ////////////////////////////////////////////////////////////////////////////
    // Hit and victim selection
    ////////////////////////////////////////////////////////////////////////////

    // Walk downward so the lowest qualifying way wins
    always_comb begin
        hit         = 1'b0;
        hit_way     = '0;
        has_invalid = 1'b0;
        invalid_way = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (probes[w].valid && probes[w].match) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
            if (!probes[w].valid) begin
                has_invalid = 1'b1;
                invalid_way = way_idx_t'(w);
            end
        end
    end

    // Way after the MRU one, wrapping
    assign mru_cur  = mru[index];
    assign mru_next = (mru_cur == way_idx_t'(`ICACHE_WAYS - 1)) ? '0 : mru_cur + 1'b1;
    assign victim   = has_invalid ? invalid_way : mru_next;

    ////////////////////////////////////////////////////////////////////////////
    // Replacement state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                mru[s] <= '0;
            end
        end else if (load && hit) begin
            mru[index] <= hit_way;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else if (!stall) begin
            resp_valid <= stage_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            resp.hit     <= hit;
            resp.hit_way <= hit_way;
            resp.victim  <= victim;
            resp.index   <= index;
        end
    end

endmodule

/* icache_tag_top.sv */
`include "icache_params.svh"

module icache_tag_top
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  logic         req_valid,
    output logic         req_ready,
    input  lookup_req_t  req,

    input  logic         maint_valid,
    input  maint_cmd_t   maint,

    output logic         resp_valid,
    input  logic         resp_ready,
    output lookup_resp_t resp
);

    way_ctrl_t  ctrl;
    way_probe_t probes [`ICACHE_WAYS];
    logic       stage_valid;
    logic       stall;

    icache_lookup_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .maint_valid (maint_valid),
        .maint       (maint),
        .stall       (stall),
        .ctrl        (ctrl),
        .stage_valid (stage_valid)
    );

    // One tag way per associativity slot
    for (genvar i = 0; i < `ICACHE_WAYS; i++) begin : g_way
        icache_tag_way #(
            .WAY_ID (i)
        ) u_way (
            .clk   (clk),
            .reset (reset),
            .ctrl  (ctrl),
            .probe (probes[i])
        );
    end

    icache_hit_resolve u_resolve (
        .clk         (clk),
        .reset       (reset),
        .stage_valid (stage_valid),
        .probes      (probes),
        .index       (ctrl.cmp_index),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp        (resp),
        .stall       (stall)
    );

endmodule

/* icache_tag_tb.sv */
`include "icache_params.svh"

module icache_tag_tb
    import icache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAND_LOOKUPS = 300;
    localparam int TEST_CYCLES  = 3 * RAND_LOOKUPS + 200;
    localparam int DRAIN_LIMIT  = 64;

    logic         clk;
    logic         reset;
    logic         req_valid;
    logic         req_ready;
    lookup_req_t  req;
    logic         maint_valid;
    maint_cmd_t   maint;
    logic         resp_valid;
    logic         resp_ready;
    lookup_resp_t resp;
    logic         backpressure;

    // Reference state with one tag and valid per way per set
    tag_t         model_tag   [`ICACHE_WAYS][`ICACHE_SETS];
    logic         model_valid [`ICACHE_WAYS][`ICACHE_SETS];
    way_idx_t     model_mru   [`ICACHE_SETS];
    lookup_resp_t exp_q [$];
    string        name_q [$];
    int           sent_count;
    int           resp_count;

    icache_tag_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .maint_valid (maint_valid),
        .maint       (maint),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp        (resp)
    );

    always #50 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic lookup_resp_t expect_lookup(input logic [`ICACHE_ADDR_W-1:0] addr);
        lookup_resp_t r;
        tag_t         tag;
        set_idx_t     set;
        logic         found_inv;
        tag       = addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        set       = addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        r         = '0;
        r.index   = set;
        found_inv = 1'b0;
        // Way after the MRU one when every way is valid
        r.victim  = way_idx_t'((int'(model_mru[set]) + 1) % `ICACHE_WAYS);
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (!r.hit && model_valid[w][set] && model_tag[w][set] == tag) begin
                r.hit     = 1'b1;
                r.hit_way = way_idx_t'(w);
            end
            if (!found_inv && !model_valid[w][set]) begin
                found_inv = 1'b1;
                r.victim  = way_idx_t'(w);
            end
        end
        return r;
    endfunction

    function automatic logic resp_matches(input lookup_resp_t e, input lookup_resp_t a);
        return e.hit == a.hit && e.index == a.index && e.victim == a.victim
            && (!e.hit || e.hit_way == a.hit_way);
    endfunction

    function automatic string format_resp(input lookup_resp_t r);
        return $sformatf("hit=%0d way=%0d victim=%0d index=%0d",
                         r.hit, r.hit_way, r.victim, r.index);
    endfunction

    task automatic update_model(input maint_cmd_t cmd);
        case (cmd.op)
            MAINT_FILL: begin
                model_tag[cmd.way][cmd.index]   = cmd.tag;
                model_valid[cmd.way][cmd.index] = 1'b1;
            end
            MAINT_INVAL: begin
                model_tag[cmd.way][cmd.index]   = '0;
                model_valid[cmd.way][cmd.index] = 1'b0;
            end
            MAINT_FLUSH: begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    for (int s = 0; s < `ICACHE_SETS; s++) begin
                        model_valid[w][s] = 1'b0;
                    end
                end
            end
            default: ;
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers entered 10 ns after a rising edge
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [`ICACHE_ADDR_W-1:0] make_addr(input tag_t tag, input int set);
        logic [31:0] rnd;
        rnd = $urandom;
        return {tag, set_idx_t'(set), rnd[`ICACHE_OFFSET_W-1:0]};
    endfunction

    // Expected value is taken at the negedge before the accepting edge
    task automatic lookup(input logic [`ICACHE_ADDR_W-1:0] addr, input string name);
        lookup_resp_t e;
        req_valid = 1'b1;
        req.addr  = addr;
        do begin
            @(negedge clk);
        end while (!req_ready);
        e = expect_lookup(addr);
        if (e.hit) begin
            model_mru[e.index] = e.hit_way;
        end
        exp_q.push_back(e);
        name_q.push_back(name);
        sent_count++;
        @(posedge clk);
        #10;
        req_valid = 1'b0;
    endtask

    // Bounded wait so lost responses show up in the final count check
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        @(posedge clk);
        #10;
    endtask

    task automatic set_maint(input maint_op_t op, input int way, input int set, input tag_t tag);
        maint.op    = op;
        maint.way   = way_idx_t'(way);
        maint.index = set_idx_t'(set);
        maint.tag   = tag;
        maint_valid = 1'b1;
        update_model(maint);
    endtask

    task automatic apply_maint(input maint_op_t op, input int way, input int set, input tag_t tag);
        drain();
        set_maint(op, way, set, tag);
        @(posedge clk);
        #10;
        maint_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Back-pressure, comparator and watchdog
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        logic [31:0] rnd;
        rnd = $urandom;
        #10;
        resp_ready = backpressure ? rnd[0] : 1'b1;
    end

    // Handshake sampled at the negedge before the edge that takes it
    always @(negedge clk) begin
        lookup_resp_t e;
        string        name;
        if (!reset) begin
            assert (req_ready || (resp_valid && !resp_ready)) else begin
                stop_run("req_ready was low while the response port was not stalled");
            end
        end
        if (resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                stop_run("A response arrived with no pending request");
            end else begin
                e    = exp_q.pop_front();
                name = name_q.pop_front();
                resp_count++;
                assert (resp_matches(e, resp)) else begin
                    $display("Fail %s: expected %s, actual %s",
                             name, format_resp(e), format_resp(resp));
                    stop_run("Response mismatch");
                end
            end
        end
    end

    initial begin
        repeat (TEST_CYCLES * 4 + 200) @(posedge clk);
        stop_run("Watchdog expired before the tests finished");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rnd;
        void'($urandom(23856));
        clk          = 1'b0;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        maint_valid  = 1'b0;
        maint        = '0;
        resp_ready   = 1'b1;
        backpressure = 1'b0;
        sent_count   = 0;
        resp_count   = 0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            model_mru[s] = '0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                model_tag[w][s]   = '0;
                model_valid[w][s] = 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;

        // Cold cache misses everywhere
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            rnd = $urandom;
            lookup(make_addr(rnd[`ICACHE_TAG_W-1:0], s), "reset_miss");
        end

        apply_maint(MAINT_FILL, 1, 3, 24'h00abcd);
        lookup(make_addr(24'h00abcd, 3), "fill_hit");
        lookup(make_addr(24'h00abce, 3), "fill_other_tag");

        // Invalidated line becomes the victim and a flush clears everything
        apply_maint(MAINT_FILL, 0, 3, 24'h001111);
        apply_maint(MAINT_INVAL, 1, 3, '0);
        lookup(make_addr(24'h00abcd, 3), "inval_miss");
        apply_maint(MAINT_FLUSH, 0, 0, '0);
        lookup(make_addr(24'h001111, 3), "flush_miss");

        // MRU-based victim once a set is full
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            apply_maint(MAINT_FILL, w, 5, tag_t'(24'h000100 + w));
        end
        for (int k = 0; k < `ICACHE_WAYS; k++) begin
            lookup(make_addr(tag_t'(24'h000100 + k), 5), "mru_hit");
            lookup(make_addr(24'h00f0f0, 5), "mru_victim");
        end

        // Fill lands at the same edge as the lookup's RAM read
        drain();
        set_maint(MAINT_FILL, 1, 9, 24'h000077);
        lookup(make_addr(24'h000077, 9), "forward");
        maint_valid = 1'b0;

        // Random traffic over a small tag space
        for (int i = 0; i < 24; i++) begin
            rnd = $urandom;
            apply_maint(MAINT_FILL, int'(rnd[9:8]) % `ICACHE_WAYS, int'(rnd[7:4]),
                        tag_t'(rnd[1:0]));
        end
        backpressure = 1'b1;
        for (int i = 0; i < RAND_LOOKUPS; i++) begin
            rnd = $urandom;
            if (rnd[31:30] == 2'd0) begin
                @(posedge clk);
                #10;
            end
            lookup(make_addr(tag_t'(rnd[1:0]), int'(rnd[7:4])), "random");
        end
        drain();
        backpressure = 1'b0;

        if (exp_q.size() != 0 || resp_count != sent_count) begin
            stop_run("Response count does not match the number of accepted requests");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

/* sim.f */
+incdir+.
icache_pkg.sv
tag_ram.sv
icache_tag_way.sv
icache_lookup_ctrl.sv
icache_hit_resolve.sv
icache_tag_top.sv
icache_tag_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the icache tag testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f sim.f --top-module icache_tag_tb \
    -Mdir obj_dir -o icache_tag_sim

./obj_dir/icache_tag_sim
